//--- logic/load_pkg.sv
package load_pkg;

  // ------------------------------
  // widths
  // ------------------------------

  // data path of the core
  localparam int unsigned XLEN = 64;
  // load address, physical equals request address
  localparam int unsigned ADDR_W = 32;
  // cache index, taken from the low address bits
  localparam int unsigned IDX_W = 12;
  // remaining upper bits form the tag
  localparam int unsigned TAG_W = ADDR_W - IDX_W;
  // scoreboard transaction id
  localparam int unsigned TRANS_ID_W = 3;
  // byte offset inside a 64 bit word
  localparam int unsigned OFFS_W = 3;
  // cache request id port, wide enough for 8 entries
  localparam int unsigned MAX_ID_W = 3;

  // ------------------------------
  // types
  // ------------------------------

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [TRANS_ID_W-1:0] trans_id_t;
  typedef logic [OFFS_W-1:0] offs_t;
  typedef logic [7:0] be_t;
  // 0 byte, 1 half, 2 word, 3 double
  typedef logic [1:0] size_t;
  typedef logic [MAX_ID_W-1:0] req_id_t;

  // integer load types, U means zero extension
  typedef enum logic [2:0] {
    LD,
    LW,
    LWU,
    LH,
    LHU,
    LB,
    LBU
  } ld_op_e;

  // transfer size code of a load type
  function automatic size_t ld_size(input ld_op_e op);
    case (op)
      LW, LWU: ld_size = 2'd2;
      LH, LHU: ld_size = 2'd1;
      LB, LBU: ld_size = 2'd0;
      default: ld_size = 2'd3;
    endcase
  endfunction

endpackage

//--- logic/ldbuf_if.sv
`timescale 1ns/1ps

interface ldbuf_if #(
  parameter int unsigned NR_LDBUF = 4
);

  // slot number width, at least one bit
  localparam int unsigned ID_W = (NR_LDBUF > 1) ? $clog2(NR_LDBUF) : 1;

  // write strobe, high on data_req and data_gnt
  logic w;
  // payload kept until the response comes back
  load_pkg::trans_id_t wdata_trans_id;
  load_pkg::offs_t wdata_offs;
  load_pkg::ld_op_e wdata_op;
  // all slots busy
  logic full;
  // lowest free slot, also the cache request id
  logic [ID_W-1:0] windex;

  // controller side
  modport ctrl (
    output w, wdata_trans_id, wdata_offs, wdata_op,
    input full, windex
  );

  // load buffer side
  modport buffer (
    input w, wdata_trans_id, wdata_offs, wdata_op,
    output full, windex
  );

endinterface

//--- logic/load_ctrl.sv
`timescale 1ns/1ps

module load_ctrl #(
  parameter int unsigned NR_LDBUF = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // issue side
  input  logic                 valid_i,
  input  load_pkg::ld_op_e     op_i,
  input  load_pkg::addr_t      addr_i,
  input  load_pkg::trans_id_t  trans_id_i,
  output logic                 pop_o,
  // store unit address check
  input  logic                 page_offset_matches_i,
  // cache request side
  input  logic                 data_gnt_i,
  output logic                 data_req_o,
  output load_pkg::idx_t       address_index_o,
  output load_pkg::tag_t       address_tag_o,
  output logic                 tag_valid_o,
  output logic                 kill_req_o,
  output load_pkg::size_t      data_size_o,
  output load_pkg::be_t        data_be_o,
  output load_pkg::req_id_t    data_id_o,
  // load buffer write port
  ldbuf_if.ctrl                ldbuf
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    SEND_TAG,
    WAIT_PAGE_OFFSET,
    WAIT_FLUSH
  } state_e;

  state_e          state_d, state_q;
  logic            accept_req;
  logic            gnt_fire;
  load_pkg::tag_t  tag_q;
  load_pkg::be_t   be_mask;

  // ------------------------------
  // request fields
  // ------------------------------

  // index goes out in the request cycle
  assign address_index_o = addr_i[load_pkg::IDX_W-1:0];
  // tag goes out one cycle later from the held copy
  assign address_tag_o   = tag_q;
  assign data_size_o     = load_pkg::ld_size(op_i);

  // contiguous byte lanes for the size
  always_comb begin
    case (data_size_o)
      2'd0:    be_mask = 8'h01;
      2'd1:    be_mask = 8'h03;
      2'd2:    be_mask = 8'h0f;
      default: be_mask = 8'hff;
    endcase
  end

  // moved up to the byte offset of the address
  assign data_be_o = be_mask << addr_i[load_pkg::OFFS_W-1:0];

  // request id is the slot that takes this load
  assign data_id_o = load_pkg::req_id_t'(ldbuf.windex);

  // ------------------------------
  // load buffer write
  // ------------------------------

  assign gnt_fire             = data_req_o & data_gnt_i;
  assign ldbuf.w              = gnt_fire;
  assign ldbuf.wdata_trans_id = trans_id_i;
  assign ldbuf.wdata_offs     = addr_i[load_pkg::OFFS_W-1:0];
  assign ldbuf.wdata_op       = op_i;

  // a new load needs a free slot
  assign accept_req = valid_i & ~ldbuf.full;

  // ------------------------------
  // load fsm
  // ------------------------------

  always_comb begin : load_fsm
    state_d     = state_q;
    data_req_o  = 1'b0;
    pop_o       = 1'b0;
    tag_valid_o = 1'b0;
    kill_req_o  = 1'b0;

    case (state_q)
      IDLE, SEND_TAG: begin
        // tag of the previous grant goes out while a new load may start
        tag_valid_o = (state_q == SEND_TAG);
        state_d     = IDLE;
        if (accept_req) begin
          if (page_offset_matches_i) begin
            // hold off while a pending store overlaps
            state_d = WAIT_PAGE_OFFSET;
          end else begin
            data_req_o = 1'b1;
            if (data_gnt_i) begin
              pop_o   = 1'b1;
              state_d = SEND_TAG;
            end else begin
              state_d = WAIT_GNT;
            end
          end
        end
      end

      WAIT_PAGE_OFFSET: begin
        // retry from the grant wait once the store is out of the way
        if (!page_offset_matches_i) begin
          state_d = WAIT_GNT;
        end
      end

      WAIT_GNT: begin
        // keep the request up until the cache takes it
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          pop_o   = 1'b1;
          state_d = SEND_TAG;
        end
      end

      WAIT_FLUSH: begin
        // close any open tag cycle with a kill
        kill_req_o  = 1'b1;
        tag_valid_o = 1'b1;
        state_d     = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // flush drops the request of this cycle and the kill follows next cycle
    if (flush_i) begin
      data_req_o = 1'b0;
      pop_o      = 1'b0;
      state_d    = WAIT_FLUSH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // hold the tag from the grant to the tag cycle
  always_ff @(posedge clk_i) begin
    if (gnt_fire) begin
      tag_q <= addr_i[load_pkg::ADDR_W-1:load_pkg::IDX_W];
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  // tag cycle follows each grant and each flush by exactly one cycle
  a_tag_after_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
    tag_valid_o == $past(gnt_fire || flush_i));

  // address must be naturally aligned for its size
  a_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> ((addr_i[load_pkg::OFFS_W-1:0]
                     & load_pkg::offs_t'((1 << data_size_o) - 1)) == '0));

endmodule

//--- logic/load_buffer.sv
`timescale 1ns/1ps

module load_buffer #(
  parameter int unsigned NR_LDBUF = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // cache response
  input  logic                 data_rvalid_i,
  input  load_pkg::req_id_t    data_rid_i,
  // result side
  output logic                 valid_o,
  output load_pkg::trans_id_t  trans_id_o,
  // read port towards the aligner
  output load_pkg::offs_t      rd_offs_o,
  output load_pkg::ld_op_e     rd_op_o,
  // write port from the controller
  ldbuf_if.buffer              ldbuf
);

  localparam int unsigned ID_W = (NR_LDBUF > 1) ? $clog2(NR_LDBUF) : 1;

  // per entry control flags
  logic [NR_LDBUF-1:0] valid_d, valid_q;
  logic [NR_LDBUF-1:0] flushed_d, flushed_q;
  // per entry payload
  load_pkg::trans_id_t trans_id_q [NR_LDBUF];
  load_pkg::offs_t     offs_q     [NR_LDBUF];
  load_pkg::ld_op_e    op_q       [NR_LDBUF];

  logic [ID_W-1:0] free_idx;
  logic [ID_W-1:0] rindex;

  // ------------------------------
  // free slot search
  // ------------------------------

  // scan downwards so the lowest free slot wins
  always_comb begin : free_search
    free_idx = '0;
    for (int i = NR_LDBUF - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_idx = ID_W'(i);
      end
    end
  end

  assign ldbuf.windex = free_idx;
  assign ldbuf.full   = &valid_q;

  // ------------------------------
  // response read
  // ------------------------------

  assign rindex     = data_rid_i[ID_W-1:0];
  assign trans_id_o = trans_id_q[rindex];
  assign rd_offs_o  = offs_q[rindex];
  assign rd_op_o    = op_q[rindex];
  // flushed loads retire silently
  assign valid_o    = data_rvalid_i & ~flushed_q[rindex];

  // ------------------------------
  // flag update
  // ------------------------------

  always_comb begin : flag_next
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // everything in flight is stale after a flush
    if (flush_i) begin
      flushed_d = flushed_q | valid_q;
    end
    // response frees its slot
    if (data_rvalid_i) begin
      valid_d[rindex] = 1'b0;
    end
    // new outstanding load, never the slot being freed
    if (ldbuf.w) begin
      valid_d[free_idx]   = 1'b1;
      flushed_d[free_idx] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ldbuf.w) begin
      trans_id_q[free_idx] <= ldbuf.wdata_trans_id;
      offs_q[free_idx]     <= ldbuf.wdata_offs;
      op_q[free_idx]       <= ldbuf.wdata_op;
    end
  end

  // response only for a load that was granted earlier
  a_rsp_valid_entry : assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rvalid_i |-> valid_q[rindex]);

  // controller never grants into a full table
  a_no_write_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ldbuf.w |-> !ldbuf.full);

endmodule

//--- logic/load_align.sv
`timescale 1ns/1ps

module load_align (
  input  load_pkg::xlen_t   data_rdata_i,
  input  load_pkg::offs_t   rd_offs_i,
  input  load_pkg::ld_op_e  rd_op_i,
  output load_pkg::xlen_t   result_o
);

  localparam int unsigned NBYTES = load_pkg::XLEN / 8;

  load_pkg::xlen_t  shifted;
  load_pkg::size_t  size;
  load_pkg::offs_t  sign_byte;
  logic [NBYTES-1:0] sign_bits;
  logic             is_signed;
  logic             sign_bit;

  // ------------------------------
  // shift
  // ------------------------------

  // bring the loaded field down to bit 0
  assign shifted = data_rdata_i >> {rd_offs_i, 3'b000};

  // ------------------------------
  // sign bit, parallel to the shift
  // ------------------------------

  // msb of every byte lane of the raw word
  for (genvar i = 0; i < NBYTES; i++) begin : gen_sign_bits
    assign sign_bits[i] = data_rdata_i[8*i+7];
  end

  assign size = load_pkg::ld_size(rd_op_i);

  // top byte of the field, offset plus bytes minus one
  assign sign_byte = rd_offs_i + load_pkg::offs_t'((1 << size) - 1);

  assign is_signed = rd_op_i inside {load_pkg::LW, load_pkg::LH, load_pkg::LB};

  // unsigned loads fill with zeros
  assign sign_bit = is_signed & sign_bits[sign_byte];

  // ------------------------------
  // extension
  // ------------------------------

  always_comb begin : extend
    case (rd_op_i)
      load_pkg::LW, load_pkg::LWU: begin
        result_o = {{(load_pkg::XLEN - 32){sign_bit}}, shifted[31:0]};
      end
      load_pkg::LH, load_pkg::LHU: begin
        result_o = {{(load_pkg::XLEN - 16){sign_bit}}, shifted[15:0]};
      end
      load_pkg::LB, load_pkg::LBU: begin
        result_o = {{(load_pkg::XLEN - 8){sign_bit}}, shifted[7:0]};
      end
      default: begin
        // LD, whole word as read
        result_o = shifted;
      end
    endcase
  end

endmodule

//--- logic/load_unit_top.sv
`timescale 1ns/1ps

module load_unit_top #(
  parameter int unsigned NR_LDBUF = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // issue buffer
  input  logic                 valid_i,
  input  load_pkg::ld_op_e     op_i,
  input  load_pkg::addr_t      addr_i,
  input  load_pkg::trans_id_t  trans_id_i,
  output logic                 pop_o,
  // store unit
  input  logic                 page_offset_matches_i,
  // data cache
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  load_pkg::req_id_t    data_rid_i,
  input  load_pkg::xlen_t      data_rdata_i,
  output logic                 data_req_o,
  output load_pkg::idx_t       address_index_o,
  output load_pkg::tag_t       address_tag_o,
  output logic                 tag_valid_o,
  output logic                 kill_req_o,
  output load_pkg::size_t      data_size_o,
  output load_pkg::be_t        data_be_o,
  output load_pkg::req_id_t    data_id_o,
  // result
  output logic                 valid_o,
  output load_pkg::trans_id_t  trans_id_o,
  output load_pkg::xlen_t      result_o
);

  // entry read by the current response
  load_pkg::offs_t  rd_offs;
  load_pkg::ld_op_e rd_op;

  ldbuf_if #(.NR_LDBUF(NR_LDBUF)) ldbuf ();

  // request path
  load_ctrl #(.NR_LDBUF(NR_LDBUF)) i_ctrl (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .op_i                  (op_i),
    .addr_i                (addr_i),
    .trans_id_i            (trans_id_i),
    .pop_o                 (pop_o),
    .page_offset_matches_i (page_offset_matches_i),
    .data_gnt_i            (data_gnt_i),
    .data_req_o            (data_req_o),
    .address_index_o       (address_index_o),
    .address_tag_o         (address_tag_o),
    .tag_valid_o           (tag_valid_o),
    .kill_req_o            (kill_req_o),
    .data_size_o           (data_size_o),
    .data_be_o             (data_be_o),
    .data_id_o             (data_id_o),
    .ldbuf                 (ldbuf.ctrl)
  );

  // outstanding loads
  load_buffer #(.NR_LDBUF(NR_LDBUF)) i_buffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rid_i    (data_rid_i),
    .valid_o       (valid_o),
    .trans_id_o    (trans_id_o),
    .rd_offs_o     (rd_offs),
    .rd_op_o       (rd_op),
    .ldbuf         (ldbuf.buffer)
  );

  // response data path
  load_align i_align (
    .data_rdata_i (data_rdata_i),
    .rd_offs_i    (rd_offs),
    .rd_op_i      (rd_op),
    .result_o     (result_o)
  );

endmodule

//--- sim/load_tb_cases.svh
`ifndef LOAD_TB_CASES_SVH
`define LOAD_TB_CASES_SVH

// bytes 0..7 are 81 72 93 64 a5 56 b7 c8
localparam load_pkg::xlen_t WORD_A = 64'hc8b7_56a5_6493_7281;
// bytes 0..7 are ef cd ab 89 67 45 23 01
localparam load_pkg::xlen_t WORD_B = 64'h0123_4567_89ab_cdef;

typedef struct packed {
  load_pkg::ld_op_e    op;
  load_pkg::addr_t     addr;
  load_pkg::trans_id_t tid;
  load_pkg::xlen_t     word;
  logic [3:0]          stall;
  logic                flush;
  load_pkg::xlen_t     exp;
} case_t;

localparam int NUM_CASES = 32;

// columns: op, addr, tid, cache word, page match cycles, flush group, expected result
localparam case_t CASES [NUM_CASES] = '{
  '{load_pkg::LB,  32'h8000_1000, 3'd0, WORD_A, 4'd0, 1'b0, 64'hffff_ffff_ffff_ff81},
  '{load_pkg::LB,  32'h8000_1001, 3'd1, WORD_A, 4'd0, 1'b0, 64'h0000_0000_0000_0072},
  '{load_pkg::LB,  32'h8000_1002, 3'd2, WORD_A, 4'd2, 1'b0, 64'hffff_ffff_ffff_ff93},
  '{load_pkg::LB,  32'h8000_1003, 3'd3, WORD_A, 4'd0, 1'b0, 64'h0000_0000_0000_0064},
  '{load_pkg::LB,  32'h8000_1004, 3'd4, WORD_A, 4'd0, 1'b0, 64'hffff_ffff_ffff_ffa5},
  '{load_pkg::LB,  32'h8000_1005, 3'd5, WORD_A, 4'd0, 1'b0, 64'h0000_0000_0000_0056},
  '{load_pkg::LB,  32'h8000_1006, 3'd6, WORD_A, 4'd0, 1'b0, 64'hffff_ffff_ffff_ffb7},
  '{load_pkg::LB,  32'h8000_1007, 3'd7, WORD_A, 4'd0, 1'b0, 64'hffff_ffff_ffff_ffc8},
  '{load_pkg::LBU, 32'h8000_2ff8, 3'd0, WORD_A, 4'd0, 1'b0, 64'h0000_0000_0000_0081},
  '{load_pkg::LBU, 32'h8000_2ff9, 3'd1, WORD_A, 4'd0, 1'b0, 64'h0000_0000_0000_0072},
  '{load_pkg::LBU, 32'h8000_2ffa, 3'd2, WORD_A, 4'd0, 1'b0, 64'h0000_0000_0000_0093},
  '{load_pkg::LBU, 32'h8000_2ffb, 3'd3, WORD_A, 4'd0, 1'b0, 64'h0000_0000_0000_0064},
  '{load_pkg::LBU, 32'h8000_2ffc, 3'd4, WORD_A, 4'd0, 1'b0, 64'h0000_0000_0000_00a5},
  '{load_pkg::LBU, 32'h8000_2ffd, 3'd5, WORD_A, 4'd3, 1'b0, 64'h0000_0000_0000_0056},
  '{load_pkg::LBU, 32'h8000_2ffe, 3'd6, WORD_A, 4'd0, 1'b0, 64'h0000_0000_0000_00b7},
  '{load_pkg::LBU, 32'h8000_2fff, 3'd7, WORD_A, 4'd0, 1'b0, 64'h0000_0000_0000_00c8},
  // flush group, responses held until after the flush
  '{load_pkg::LW,  32'h0000_0a04, 3'd0, WORD_B, 4'd0, 1'b1, 64'h0000_0000_0123_4567},
  '{load_pkg::LH,  32'h0000_0a10, 3'd1, WORD_B, 4'd0, 1'b1, 64'hffff_ffff_ffff_cdef},
  '{load_pkg::LB,  32'h0000_0a1b, 3'd2, WORD_B, 4'd0, 1'b1, 64'hffff_ffff_ffff_ff89},
  '{load_pkg::LH,  32'h1234_5670, 3'd3, WORD_A, 4'd0, 1'b0, 64'h0000_0000_0000_7281},
  '{load_pkg::LH,  32'h1234_5672, 3'd4, WORD_A, 4'd0, 1'b0, 64'h0000_0000_0000_6493},
  '{load_pkg::LH,  32'h1234_5674, 3'd5, WORD_A, 4'd2, 1'b0, 64'h0000_0000_0000_56a5},
  '{load_pkg::LH,  32'h1234_5676, 3'd6, WORD_A, 4'd0, 1'b0, 64'hffff_ffff_ffff_c8b7},
  '{load_pkg::LHU, 32'h7ffe_e000, 3'd7, WORD_A, 4'd0, 1'b0, 64'h0000_0000_0000_7281},
  '{load_pkg::LHU, 32'h7ffe_e002, 3'd0, WORD_A, 4'd0, 1'b0, 64'h0000_0000_0000_6493},
  '{load_pkg::LHU, 32'h7ffe_e004, 3'd1, WORD_A, 4'd0, 1'b0, 64'h0000_0000_0000_56a5},
  '{load_pkg::LHU, 32'h7ffe_e006, 3'd2, WORD_A, 4'd0, 1'b0, 64'h0000_0000_0000_c8b7},
  '{load_pkg::LW,  32'h4000_0000, 3'd3, WORD_A, 4'd3, 1'b0, 64'h0000_0000_6493_7281},
  '{load_pkg::LW,  32'h4000_0004, 3'd4, WORD_A, 4'd0, 1'b0, 64'hffff_ffff_c8b7_56a5},
  '{load_pkg::LWU, 32'h4000_0808, 3'd5, WORD_A, 4'd0, 1'b0, 64'h0000_0000_6493_7281},
  '{load_pkg::LWU, 32'h4000_080c, 3'd6, WORD_A, 4'd0, 1'b0, 64'h0000_0000_c8b7_56a5},
  '{load_pkg::LD,  32'hfff0_0ff8, 3'd7, WORD_A, 4'd0, 1'b0, 64'hc8b7_56a5_6493_7281}
};

`endif

//--- sim/load_unit_tb.sv
`timescale 1ns/1ps

module load_unit_tb;

  `include "load_tb_cases.svh"

  localparam int NUM_IDS = 2 ** load_pkg::MAX_ID_W;

  // clock, reset and flush
  logic                clk_i = 1'b0;
  logic                rst_ni;
  logic                flush_i;
  // issue side
  logic                valid_i;
  load_pkg::ld_op_e    op_i;
  load_pkg::addr_t     addr_i;
  load_pkg::trans_id_t trans_id_i;
  logic                pop_o;
  logic                page_offset_matches_i;
  // cache side
  logic                data_gnt_i;
  logic                data_rvalid_i;
  load_pkg::req_id_t   data_rid_i;
  load_pkg::xlen_t     data_rdata_i;
  logic                data_req_o;
  load_pkg::idx_t      address_index_o;
  load_pkg::tag_t      address_tag_o;
  logic                tag_valid_o;
  logic                kill_req_o;
  load_pkg::size_t     data_size_o;
  load_pkg::be_t       data_be_o;
  load_pkg::req_id_t   data_id_o;
  // result side
  logic                valid_o;
  load_pkg::trans_id_t trans_id_o;
  load_pkg::xlen_t     result_o;

  // cache model with one slot per request id
  logic pend_valid [NUM_IDS];
  logic pend_flushed [NUM_IDS];
  int   pend_due [NUM_IDS];
  int   pend_case [NUM_IDS];
  // request tracking
  logic           hold_rsp;
  logic           popped;
  logic           last_fire;
  logic           last_flush;
  logic           last_req_wait;
  load_pkg::tag_t last_tag;
  int             gnt_wait;
  int             req_cycles;
  int             cur_case;
  // counters
  int     errors;
  int     passed;
  int     failed;
  int     finished;
  int     kill_cycles;
  int     flushes;
  integer seed;

  always #5 clk_i = ~clk_i;

  load_unit_top #(.NR_LDBUF(4)) DUT (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .op_i                  (op_i),
    .addr_i                (addr_i),
    .trans_id_i            (trans_id_i),
    .pop_o                 (pop_o),
    .page_offset_matches_i (page_offset_matches_i),
    .data_gnt_i            (data_gnt_i),
    .data_rvalid_i         (data_rvalid_i),
    .data_rid_i            (data_rid_i),
    .data_rdata_i          (data_rdata_i),
    .data_req_o            (data_req_o),
    .address_index_o       (address_index_o),
    .address_tag_o         (address_tag_o),
    .tag_valid_o           (tag_valid_o),
    .kill_req_o            (kill_req_o),
    .data_size_o           (data_size_o),
    .data_be_o             (data_be_o),
    .data_id_o             (data_id_o),
    .valid_o               (valid_o),
    .trans_id_o            (trans_id_o),
    .result_o              (result_o)
  );

  // ------------------------------
  // compare tasks
  // ------------------------------

  task automatic report_failure(input string what);
    $display("at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_result(input load_pkg::xlen_t got, input load_pkg::xlen_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t result_o got %h expected %h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_trans_id(input load_pkg::trans_id_t got,
                                input load_pkg::trans_id_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t trans_id_o got %0d expected %0d", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_index(input load_pkg::idx_t got, input load_pkg::idx_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t address_index_o got %h expected %h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_tag(input load_pkg::tag_t got, input load_pkg::tag_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t address_tag_o got %h expected %h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_size(input load_pkg::size_t got, input load_pkg::size_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t data_size_o got %0d expected %0d", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_be(input load_pkg::be_t got, input load_pkg::be_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t data_be_o got %b expected %b", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_idle_outputs();
    check_bit("data_req_o", data_req_o, 1'b0);
    check_bit("pop_o", pop_o, 1'b0);
    check_bit("tag_valid_o", tag_valid_o, 1'b0);
    check_bit("kill_req_o", kill_req_o, 1'b0);
    check_bit("valid_o", valid_o, 1'b0);
  endtask

  // ------------------------------
  // expected request fields
  // ------------------------------

  // bytes read by each load type
  function automatic int load_bytes(input load_pkg::ld_op_e op);
    case (op)
      load_pkg::LB, load_pkg::LBU: return 1;
      load_pkg::LH, load_pkg::LHU: return 2;
      load_pkg::LW, load_pkg::LWU: return 4;
      default: return 8;
    endcase
  endfunction

  // 0 byte, 1 half, 2 word, 3 double
  function automatic load_pkg::size_t size_code(input int bytes);
    case (bytes)
      1: return 2'd0;
      2: return 2'd1;
      4: return 2'd2;
      default: return 2'd3;
    endcase
  endfunction

  // one lane for every byte from the offset on
  function automatic load_pkg::be_t lane_mask(input int bytes, input int offs);
    load_pkg::be_t mask;
    for (int k = 0; k < 8; k++) begin
      mask[k] = (k >= offs) && (k < offs + bytes);
    end
    return mask;
  endfunction

  // ------------------------------
  // cache model and monitor
  // ------------------------------

  // grant after gnt_wait request cycles and answer the lowest ready id
  task automatic drive_cache();
    int rid;
    rid = -1;
    data_gnt_i = (req_cycles >= gnt_wait);
    for (int id = 0; id < NUM_IDS; id++) begin
      if (pend_valid[id] && pend_due[id] > 0) pend_due[id]--;
    end
    if (!hold_rsp) begin
      for (int id = NUM_IDS - 1; id >= 0; id--) begin
        if (pend_valid[id] && pend_due[id] == 0) rid = id;
      end
    end
    data_rvalid_i = (rid >= 0);
    data_rid_i    = (rid >= 0) ? load_pkg::req_id_t'(rid) : '0;
    data_rdata_i  = (rid >= 0) ? CASES[pend_case[rid]].word : '0;
  endtask

  task automatic observe();
    logic fire;
    int id;
    int bytes;
    int errs_before;
    case_t c;
    case_t req;
    load_pkg::ld_op_e op;
    string note;
    fire = data_req_o && data_gnt_i;
    // handshake rules of the request side
    check_bit("pop_o", pop_o, fire);
    if (page_offset_matches_i) check_bit("data_req_o", data_req_o, 1'b0);
    if (last_req_wait && !flush_i) check_bit("data_req_o", data_req_o, 1'b1);
    check_bit("tag_valid_o", tag_valid_o, last_fire || last_flush);
    check_bit("kill_req_o", kill_req_o, last_flush);
    if (kill_req_o && tag_valid_o) kill_cycles++;
    // request fields of the load being issued
    if (data_req_o) begin
      req   = CASES[cur_case];
      bytes = load_bytes(req.op);
      check_index(address_index_o, req.addr[load_pkg::IDX_W-1:0]);
      check_size(data_size_o, size_code(bytes));
      check_be(data_be_o, lane_mask(bytes, int'(req.addr[2:0])));
    end
    // held tag in the cycle after a grant
    if (last_fire) check_tag(address_tag_o, last_tag);
    // response checked against the entry of data_rid_i
    if (data_rvalid_i) begin
      id = int'(data_rid_i);
      c = CASES[pend_case[id]];
      op = c.op;
      errs_before = errors;
      note = pend_flushed[id] ? " flushed" : "";
      check_bit("valid_o", valid_o, !pend_flushed[id]);
      if (!pend_flushed[id] && valid_o === 1'b1) begin
        check_result(result_o, c.exp);
        check_trans_id(trans_id_o, c.tid);
      end
      if (errors == errs_before) passed++;
      else failed++;
      $display("case %0d %s id %0d%s: %s", pend_case[id], op.name(), id, note,
               (errors == errs_before) ? "ok" : "FAIL");
      pend_valid[id] = 1'b0;
      finished++;
    end else begin
      check_bit("valid_o", valid_o, 1'b0);
    end
    if (flush_i) begin
      for (int i = 0; i < NUM_IDS; i++) pend_flushed[i] = pend_flushed[i] | pend_valid[i];
    end
    // new outstanding load
    if (fire) begin
      id = int'(data_id_o);
      if (pend_valid[id]) report_failure("data_id_o reused while still outstanding");
      pend_valid[id]   = 1'b1;
      pend_flushed[id] = 1'b0;
      pend_case[id]    = cur_case;
      pend_due[id]     = 1 + $unsigned($random(seed)) % 6;
      gnt_wait         = $unsigned($random(seed)) % 4;
      req_cycles       = 0;
      popped           = 1'b1;
      last_tag         = CASES[cur_case].addr[load_pkg::ADDR_W-1:load_pkg::IDX_W];
    end else if (data_req_o) begin
      req_cycles++;
    end
    last_fire     = fire;
    last_flush    = flush_i;
    last_req_wait = data_req_o && !data_gnt_i;
  endtask

  // one cycle with inputs on the falling edge and outputs read 1 ns later
  task automatic tick(input logic v, input case_t c, input logic pm, input logic fl);
    @(negedge clk_i);
    valid_i               = v;
    op_i                  = c.op;
    addr_i                = c.addr;
    trans_id_i            = c.tid;
    page_offset_matches_i = pm;
    flush_i               = fl;
    drive_cache();
    #1;
    observe();
  endtask

  task automatic idle_cycle();
    tick(1'b0, CASES[0], 1'b0, 1'b0);
  endtask

  task automatic issue_load(input int idx);
    int stall;
    stall    = int'(CASES[idx].stall);
    cur_case = idx;
    popped   = 1'b0;
    while (!popped) begin
      tick(1'b1, CASES[idx], stall > 0, 1'b0);
      if (stall > 0) stall--;
    end
  endtask

  function automatic int pending_count();
    int n;
    n = 0;
    for (int i = 0; i < NUM_IDS; i++) n += int'(pend_valid[i]);
    return n;
  endfunction

  task automatic drain();
    while (pending_count() > 0) idle_cycle();
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    seed = 39948;
    rst_ni = 1'b0;
    flush_i = 1'b0;
    valid_i = 1'b0;
    page_offset_matches_i = 1'b0;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    op_i = load_pkg::LD;
    addr_i = '0;
    trans_id_i = '0;
    data_rid_i = '0;
    data_rdata_i = '0;
    hold_rsp = 1'b0;
    popped = 1'b0;
    last_fire = 1'b0;
    last_flush = 1'b0;
    last_req_wait = 1'b0;
    last_tag = '0;
    errors = 0;
    passed = 0;
    failed = 0;
    finished = 0;
    kill_cycles = 0;
    flushes = 0;
    req_cycles = 0;
    cur_case = 0;
    for (int i = 0; i < NUM_IDS; i++) begin
      pend_valid[i] = 1'b0;
      pend_flushed[i] = 1'b0;
      pend_due[i] = 0;
      pend_case[i] = 0;
    end
    gnt_wait = $unsigned($random(seed)) % 4;
    // reset for two cycles
    @(negedge clk_i);
    #1;
    check_idle_outputs();
    @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (3) begin
      idle_cycle();
      check_idle_outputs();
    end
    for (int i = 0; i < NUM_CASES; i++) begin
      // a flush group starts from an empty table
      if (CASES[i].flush && !hold_rsp) begin
        drain();
        hold_rsp = 1'b1;
      end
      issue_load(i);
      if (CASES[i].flush && (i == NUM_CASES - 1 || !CASES[i + 1].flush)) begin
        idle_cycle();
        tick(1'b0, CASES[0], 1'b0, 1'b1);
        flushes++;
        hold_rsp = 1'b0;
      end
    end
    drain();
    repeat (2) idle_cycle();
    if (finished != NUM_CASES) report_failure("not every load got a response");
    if (kill_cycles != flushes) report_failure("kill cycles do not match the flushes");
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             NUM_CASES, passed, failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // about 20 cycles per load plus margin
  initial begin
    repeat (NUM_CASES * 20 + 200) @(posedge clk_i);
    $display("timeout with %0d of %0d loads finished", finished, NUM_CASES);
    $display("test failed");
    $finish;
  end

endmodule

//--- load_unit_top.f
+incdir+sim
logic/load_pkg.sv
logic/ldbuf_if.sv
logic/load_ctrl.sv
logic/load_buffer.sv
logic/load_align.sv
logic/load_unit_top.sv
sim/load_unit_tb.sv

//--- Makefile
# Verilator build and run for the load unit testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module load_unit_tb -f load_unit_top.f \
		--Mdir obj_dir -o load_unit_tb

run: compile
	./obj_dir/load_unit_tb | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
